// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = instrCacheTb
FILELIST  = files.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: files.f
hdl/instrCachePkg.sv
hdl/cacheArrayIf.sv
hdl/instrCacheMemory.sv
hdl/instrCacheController.sv
hdl/instrCache.sv
sim/busModel.sv
sim/instrCache_properties.sv
sim/instrCacheTb.sv

// File: hdl/cacheArrayIf.sv
//////////////////////////////////////////////////////////////////////
// Tag, valid, LRU and write enable traffic between the cache
// controller and the way arrays
//////////////////////////////////////////////////////////////////////
interface cacheArrayIf import instrCachePkg::*; #(
    parameter int blockWords = 4,
    parameter int sets       = 2
) ();

    // Lookup results for the addressed set
    logic                                    w1Valid;
    logic                                    w2Valid;
    logic [tagWidthOf(blockWords, sets)-1:0] w1Tag;
    logic [tagWidthOf(blockWords, sets)-1:0] w2Tag;
    logic                                    curLru;

    // Fill and LRU update requests
    logic                                    w1We;
    logic                                    w2We;
    logic [offsetWidthOf(blockWords)-1:0]    fillWord;
    logic                                    touchWay;
    logic                                    touchValid;

    modport array (
        output w1Valid, w2Valid, w1Tag, w2Tag, curLru,
        input  w1We, w2We, fillWord, touchWay, touchValid
    );

    modport ctrl (
        input  w1Valid, w2Valid, w1Tag, w2Tag, curLru,
        output w1We, w2We, fillWord, touchWay, touchValid
    );

endinterface

// File: hdl/instrCache.sv
//////////////////////////////////////////////////////////////////////
// Two-way set associative instruction cache top level with way
// select, bypass steering and bus address forming
//////////////////////////////////////////////////////////////////////
module instrCache import instrCachePkg::*; #(
    parameter int blockWords = 4,
    parameter int sets       = 2
) (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    enable,
    input  logic                                    invalidate,
    input  logic                                    paReady,
    input  addrT                                    fetchAddr,
    input  logic [tagWidthOf(blockWords, sets)-1:0] physTag,
    input  logic                                    busReady,
    input  instrWordT                               hRData,
    output instrWordT                               rd,
    output addrT                                    hAddrF,
    output logic                                    iStall,
    output logic                                    hRequestF
);

    localparam int IB = indexWidthOf(sets);
    localparam int OB = offsetWidthOf(blockWords);

    logic [IB-1:0] setIdx;
    logic [OB-1:0] wordOff;
    logic [OB-1:0] addrWordOffset;
    instrWordT     w1Rd;
    instrWordT     w2Rd;
    instrWordT     cacheOut;
    logic          waySel;

    // Index and word offset are untranslated address bits
    assign setIdx  = IB'(setIndexOf(fetchAddr, blockWords, sets));
    assign wordOff = OB'(wordOffsetOf(fetchAddr, blockWords));

    // Physical word address, offset comes from the fill counter
    assign hAddrF = {physTag, setIdx, addrWordOffset, 2'b00};

    cacheArrayIf #(
        .blockWords(blockWords),
        .sets      (sets)
    ) arrIf ();

    instrCacheMemory #(
        .blockWords(blockWords),
        .sets      (sets)
    ) icm (
        .clk       (clk),
        .reset     (reset),
        .invalidate(invalidate),
        .arr       (arrIf.array),
        .setIndex  (setIdx),
        .readWord  (wordOff),
        .physTag   (physTag),
        .fillData  (hRData),
        .w1Rd      (w1Rd),
        .w2Rd      (w2Rd)
    );

    instrCacheController #(
        .blockWords(blockWords),
        .sets      (sets)
    ) icc (
        .clk           (clk),
        .reset         (reset),
        .enable        (enable),
        .paReady       (paReady),
        .busReady      (busReady),
        .arr           (arrIf.ctrl),
        .physTag       (physTag),
        .wordOffset    (wordOff),
        .waySel        (waySel),
        .iStall        (iStall),
        .hRequestF     (hRequestF),
        .addrWordOffset(addrWordOffset)
    );

    // Way select, then bus data when the arrays are bypassed
    assign cacheOut = waySel ? w2Rd : w1Rd;
    assign rd       = enable ? cacheOut : hRData;

endmodule

// File: hdl/instrCacheController.sv
//////////////////////////////////////////////////////////////////////
// Hit detection, victim choice, miss fill and bypass FSM, bus
// request and fetch stall generation
//////////////////////////////////////////////////////////////////////
module instrCacheController import instrCachePkg::*; #(
    parameter int blockWords = 4,
    parameter int sets       = 2
) (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    enable,
    input  logic                                    paReady,
    input  logic                                    busReady,
    cacheArrayIf.ctrl                               arr,
    input  logic [tagWidthOf(blockWords, sets)-1:0] physTag,
    input  logic [offsetWidthOf(blockWords)-1:0]    wordOffset,
    output logic                                    waySel,
    output logic                                    iStall,
    output logic                                    hRequestF,
    output logic [offsetWidthOf(blockWords)-1:0]    addrWordOffset
);

    localparam int OB = offsetWidthOf(blockWords);
    localparam logic [OB-1:0] LAST_WORD = OB'(blockWords - 1);

    fillStateT     state;
    fillStateT     nextState;
    logic [OB-1:0] wordCount;
    logic          victim;
    logic          victimWay;
    logic          w1Hit;
    logic          w2Hit;
    logic          hit;
    logic          lookup;

    // Tag compare on both ways
    assign w1Hit  = arr.w1Valid && (arr.w1Tag == physTag);
    assign w2Hit  = arr.w2Valid && (arr.w2Tag == physTag);
    assign hit    = w1Hit || w2Hit;
    assign lookup = paReady && enable;
    assign waySel = w2Hit;

    // Invalid way first, otherwise the way not used last
    always_comb begin
        if (!arr.w1Valid) begin
            victim = 1'b0;
        end else if (!arr.w2Valid) begin
            victim = 1'b1;
        end else begin
            victim = !arr.curLru;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            wordCount <= '0;
            victimWay <= 1'b0;
        end else begin
            state <= nextState;
            if (state == IDLE) begin
                // Victim is frozen at the edge that starts the fill
                wordCount <= '0;
                victimWay <= victim;
            end else if (state == FILL && busReady) begin
                wordCount <= wordCount + OB'(1);
            end
        end
    end

    always_comb begin
        nextState = state;
        unique case (state)
            IDLE: begin
                if (paReady && !enable) begin
                    nextState = BYPASS;
                end else if (lookup && !hit) begin
                    nextState = FILL;
                end
            end
            FILL: begin
                if (busReady && wordCount == LAST_WORD) begin
                    nextState = DONE;
                end
            end
            BYPASS: begin
                if (busReady) begin
                    nextState = IDLE;
                end
            end
            DONE: nextState = IDLE;
            default: nextState = IDLE;
        endcase
    end

    // Stall, request and bus word offset
    always_comb begin
        iStall         = 1'b0;
        hRequestF      = 1'b0;
        addrWordOffset = wordOffset;
        unique case (state)
            IDLE: iStall = paReady && !(enable && hit);
            FILL: begin
                iStall         = 1'b1;
                hRequestF      = 1'b1;
                addrWordOffset = wordCount;
            end
            BYPASS: begin
                // Word goes straight to rd in the busReady cycle
                iStall    = !busReady;
                hRequestF = 1'b1;
            end
            DONE: iStall = 1'b1;
            default: iStall = 1'b0;
        endcase
    end

    // Fill writes land on the victim way
    assign arr.w1We     = (state == FILL) && busReady && !victimWay;
    assign arr.w2We     = (state == FILL) && busReady && victimWay;
    assign arr.fillWord = wordCount;

    // Hits mark their way as most recently used
    assign arr.touchValid = (state == IDLE) && lookup && hit;
    assign arr.touchWay   = waySel;

endmodule

// File: hdl/instrCacheMemory.sv
//////////////////////////////////////////////////////////////////////
// Two-way tag, valid, LRU and data arrays with asynchronous word
// reads and a one word per cycle fill port
//////////////////////////////////////////////////////////////////////
module instrCacheMemory import instrCachePkg::*; #(
    parameter int blockWords = 4,
    parameter int sets       = 2
) (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    invalidate,
    cacheArrayIf.array                              arr,
    input  logic [indexWidthOf(sets)-1:0]           setIndex,
    input  logic [offsetWidthOf(blockWords)-1:0]    readWord,
    input  logic [tagWidthOf(blockWords, sets)-1:0] physTag,
    input  instrWordT                               fillData,
    output instrWordT                               w1Rd,
    output instrWordT                               w2Rd
);

    localparam int TB = tagWidthOf(blockWords, sets);
    localparam int OB = offsetWidthOf(blockWords);
    localparam logic [OB-1:0] LAST_WORD = OB'(blockWords - 1);

    // Index 0 is way 1, index 1 is way 2
    instrWordT       data  [2][sets][blockWords];
    logic [TB-1:0]   tags  [2][sets];
    logic [sets-1:0] valid [2];

    // One bit per set holding the most recently used way
    logic [sets-1:0] lru;

    logic [1:0] wayWe;
    logic       lastWord;

    assign wayWe    = {arr.w2We, arr.w1We};
    assign lastWord = (arr.fillWord == LAST_WORD);

    // Fill data and tag storage
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (wayWe[w]) begin
                data[w][setIndex][arr.fillWord] <= fillData;
                // Tag goes in with the last word of the block
                if (lastWord) begin
                    tags[w][setIndex] <= physTag;
                end
            end
        end
    end

    // Valid and LRU state
    always_ff @(posedge clk) begin
        if (reset) begin
            valid[0] <= '0;
            valid[1] <= '0;
            lru      <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (invalidate) begin
                    valid[w] <= '0;
                end else if (wayWe[w] && lastWord) begin
                    valid[w][setIndex] <= 1'b1;
                end
            end
            if (arr.touchValid) begin
                lru[setIndex] <= arr.touchWay;
            end
        end
    end

    // Lookup side for the addressed set
    assign arr.w1Valid = valid[0][setIndex];
    assign arr.w2Valid = valid[1][setIndex];
    assign arr.w1Tag   = tags[0][setIndex];
    assign arr.w2Tag   = tags[1][setIndex];
    assign arr.curLru  = lru[setIndex];

    // Asynchronous word reads
    assign w1Rd = data[0][setIndex][readWord];
    assign w2Rd = data[1][setIndex][readWord];

endmodule

// File: hdl/instrCachePkg.sv
//////////////////////////////////////////////////////////////////////
// Instruction word and address types, fill FSM states and the
// address field helpers shared by the cache blocks
//////////////////////////////////////////////////////////////////////
package instrCachePkg;

    localparam int WORD_BITS = 32;

    typedef logic [WORD_BITS-1:0] instrWordT;
    typedef logic [WORD_BITS-1:0] addrT;

    // Controller states
    typedef enum logic [1:0] {
        IDLE,
        FILL,
        BYPASS,
        DONE
    } fillStateT;

    // Field widths
    function automatic int offsetWidthOf(int blockWords);
        return $clog2(blockWords);
    endfunction

    function automatic int indexWidthOf(int sets);
        return $clog2(sets);
    endfunction

    // Two byte-offset bits sit below the word offset
    function automatic int tagWidthOf(int blockWords, int sets);
        return WORD_BITS - 2 - offsetWidthOf(blockWords) - indexWidthOf(sets);
    endfunction

    // Field extraction from a byte address
    function automatic int setIndexOf(addrT addr, int blockWords, int sets);
        addrT shifted;
        shifted = addr >> (2 + offsetWidthOf(blockWords));
        return int'(shifted & addrT'(sets - 1));
    endfunction

    function automatic int wordOffsetOf(addrT addr, int blockWords);
        return int'((addr >> 2) & addrT'(blockWords - 1));
    endfunction

endpackage

// File: sim/busModel.sv
//////////////////////////////////////////////////////////////////////
// Behavioral system bus memory answering word requests after an
// LFSR driven latency of one to four cycles
//////////////////////////////////////////////////////////////////////
module busModel import instrCachePkg::*; #(
    parameter instrWordT PATTERN = 32'h600D_F000
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      hRequestF,
    input  addrT      hAddrF,
    output instrWordT hRData,
    output logic      busReady
);

    localparam int          DRIVE_DELAY = 1;
    localparam logic [15:0] SEED        = 16'd7200;

    logic [15:0] lfsrState;
    logic        busy;
    int          waitLeft;

    // Taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        logic feedback;
        feedback = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], feedback};
    endfunction

    // Two LFSR bits, one step per bit
    function automatic int drawLatency();
        int lat;
        lat = 1;
        for (int b = 0; b < 2; b++) begin
            lfsrState = lfsrStep(lfsrState);
            lat += int'(lfsrState[0]) << b;
        end
        return lat;
    endfunction

    initial begin
        lfsrState = SEED;
        busy      = 1'b0;
        waitLeft  = 0;
        busReady  = 1'b0;
        hRData    = '0;
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (reset) begin
                busy     = 1'b0;
                busReady = 1'b0;
            end else if (busReady) begin
                // Word was taken at this edge
                busReady = 1'b0;
            end else if (hRequestF) begin
                if (!busy) begin
                    busy     = 1'b1;
                    waitLeft = drawLatency();
                end else if (waitLeft > 1) begin
                    waitLeft--;
                end else begin
                    busy     = 1'b0;
                    busReady = 1'b1;
                    hRData   = hAddrF ^ PATTERN;
                end
            end
        end
    end

endmodule

// File: sim/fetchTrace.txt
// fetchAddr physTag enable invalidate expectedWord expectedMiss, all hex
// Expected word is the physical word address XOR 600DF000
00000100 00000008 1 0 600DF100 1
00000104 00000008 1 0 600DF104 0
00000108 00000008 1 0 600DF108 0
0000010C 00000008 1 0 600DF10C 0
00000200 00000010 1 0 600DF200 1
00000204 00000010 1 0 600DF204 0
0000010C 00000008 1 0 600DF10C 0
00000300 00000018 1 0 600DF300 1
00000200 00000010 1 0 600DF200 1
00000308 00000018 1 0 600DF308 0
00000100 00000008 1 0 600DF100 1
00000304 00000018 1 0 600DF304 0
00000110 00000008 1 0 600DF110 1
0000011C 00000008 1 0 600DF11C 0
00000430 00000021 1 0 600DF430 1
00000104 00000008 1 1 600DF104 1
00000114 00000008 1 0 600DF114 1
00000108 00000008 1 0 600DF108 0
00000438 00000021 0 0 600DF438 1
0000043C 00000021 0 0 600DF43C 1
00000304 00000018 0 0 600DF304 1
00000104 00000008 0 0 600DF104 1
00000430 00000021 1 0 600DF430 1
00000434 00000021 1 0 600DF434 0
00000300 00000018 1 0 600DF300 1
00000200 00000010 1 0 600DF200 1
0000020C 00000010 1 0 600DF20C 0
0000030C 00000018 1 0 600DF30C 0
00000100 00000008 1 0 600DF100 1
00000108 00000008 1 0 600DF108 0
00000110 00000008 1 0 600DF110 0
00000118 00000008 1 0 600DF118 0
00000438 00000021 1 0 600DF438 0
00000304 00000018 1 0 600DF304 0
00000104 00000008 1 0 600DF104 0
00000200 00000010 1 0 600DF200 1
00000208 00000010 1 0 600DF208 0
00000300 00000018 1 0 600DF300 1
00000204 00000010 1 0 600DF204 0
00000100 00000008 1 0 600DF100 1

// File: sim/instrCacheTb.sv
//////////////////////////////////////////////////////////////////////
// Trace driven instruction cache testbench with data and miss
// checks, bus model and run watchdog
//////////////////////////////////////////////////////////////////////
module instrCacheTb import instrCachePkg::*; ();

    localparam int BLOCK_WORDS  = 4;
    localparam int SETS         = 2;
    localparam int TAG_BITS     = tagWidthOf(BLOCK_WORDS, SETS);
    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 1;
    localparam int RESET_CYCLES = 8;
    localparam int MAX_ACCESSES = 64;
    localparam int COLUMNS      = 6;
    // Up to six bus cycles per word, plus lookup, done, replay and hold
    localparam int MISS_CYCLES  = BLOCK_WORDS * 6 + 4;

    logic                clk = 1'b0;
    logic                reset;
    logic                enable;
    logic                invalidate;
    logic                paReady;
    addrT                fetchAddr;
    logic [TAG_BITS-1:0] physTag;
    logic                busReady;
    instrWordT           hRData;
    instrWordT           rd;
    addrT                hAddrF;
    logic                iStall;
    logic                hRequestF;

    logic [31:0] traceMem [MAX_ACCESSES*COLUMNS];
    int          numAccesses;
    int          curAccess;
    int          dataErrors;
    int          missErrors;
    int          otherErrors;
    logic        traceLoaded = 1'b0;

    instrCache #(.blockWords(BLOCK_WORDS), .sets(SETS)) uut (.*);

    busModel #(.PATTERN(32'h600D_F000)) bus (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // One trace access: optional invalidate, fetch, wait for stall to clear
    task automatic runFetch(input int idx);
        addrT                addr;
        logic [TAG_BITS-1:0] tag;
        logic                inv;
        instrWordT           expWord;
        logic                expMiss;
        logic                sawRequest;
        addr    = traceMem[idx*COLUMNS];
        tag     = traceMem[idx*COLUMNS+1][TAG_BITS-1:0];
        inv     = traceMem[idx*COLUMNS+3][0];
        expWord = traceMem[idx*COLUMNS+4];
        expMiss = traceMem[idx*COLUMNS+5][0];
        @(posedge clk);
        #DRIVE_DELAY;
        if (inv) begin
            paReady    = 1'b0;
            invalidate = 1'b1;
            @(posedge clk);
            #DRIVE_DELAY;
            invalidate = 1'b0;
        end
        paReady    = 1'b1;
        enable     = traceMem[idx*COLUMNS+2][0];
        fetchAddr  = addr;
        physTag    = tag;
        sawRequest = 1'b0;
        do begin
            @(negedge clk);
            if (hRequestF) begin
                sawRequest = 1'b1;
            end
        end while (iStall);
        if (rd !== expWord) begin
            $display("Error: rd = %h, expected %h (access %0d, fetchAddr %h)",
                     rd, expWord, idx, addr);
            dataErrors++;
        end
        if (sawRequest !== expMiss) begin
            $display("Error: hRequestF seen = %h, expected %h (access %0d, fetchAddr %h)",
                     sawRequest, expMiss, idx, addr);
            missErrors++;
        end
        // Cached hit stays presented for one more cycle
        if (enable) begin
            @(posedge clk);
        end
    endtask

    initial begin
        reset       = 1'b1;
        enable      = 1'b1;
        invalidate  = 1'b0;
        paReady     = 1'b0;
        fetchAddr   = '0;
        physTag     = '0;
        dataErrors  = 0;
        missErrors  = 0;
        otherErrors = 0;
        curAccess   = 0;
        // All ones past the last trace line marks its end
        for (int i = 0; i < MAX_ACCESSES * COLUMNS; i++) begin
            traceMem[i] = '1;
        end
        $readmemh("sim/fetchTrace.txt", traceMem);
        numAccesses = 0;
        while (numAccesses < MAX_ACCESSES && traceMem[numAccesses*COLUMNS] != '1) begin
            numAccesses++;
        end
        if (numAccesses == 0) begin
            $display("The fetch trace holds no accesses");
            otherErrors++;
        end
        traceLoaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        @(negedge clk);
        if (iStall || hRequestF) begin
            $display("Stall or bus request is active right after reset");
            otherErrors++;
        end
        for (int i = 0; i < numAccesses; i++) begin
            curAccess = i;
            runFetch(i);
        end
        @(posedge clk);
        #DRIVE_DELAY;
        paReady = 1'b0;
        repeat (2) @(posedge clk);
        $display("Accesses %0d, data errors %0d, miss errors %0d, other errors %0d",
                 numAccesses, dataErrors, missErrors, otherErrors);
        if (dataErrors + missErrors + otherErrors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog sized from the trace length and the slowest miss
    initial begin
        wait (traceLoaded);
        #((RESET_CYCLES + 4 + (numAccesses + 1) * MISS_CYCLES) * CLK_PERIOD);
        $display("Timeout while waiting for access %0d to complete", curAccess);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: sim/instrCache_properties.sv
//////////////////////////////////////////////////////////////////////
// Stall, bus request and hit data assertions bound to instrCache
//////////////////////////////////////////////////////////////////////
module instrCache_properties import instrCachePkg::*; (
    input logic      clk,
    input logic      reset,
    input logic      enable,
    input logic      paReady,
    input addrT      fetchAddr,
    input logic      busReady,
    input logic      iStall,
    input logic      hRequestF,
    input instrWordT rd
);

    logic hitHeld;

    // Cached fetch completing without a stall
    assign hitHeld = paReady && enable && !iStall;

    // Only the bypass word cycle may request with fetch running
    assert property (@(posedge clk) disable iff (reset)
        hRequestF && !busReady |-> iStall)
        else $error("bus request active while fetch is not stalled");

    assert property (@(posedge clk) disable iff (reset)
        busReady |-> hRequestF)
        else $error("busReady arrived without a bus request");

    assert property (@(posedge clk) disable iff (reset)
        hitHeld && $past(hitHeld) && $stable(fetchAddr) |-> $stable(rd))
        else $error("rd changed while the same hit was held");

endmodule

bind instrCache instrCache_properties props (
    .clk      (clk),
    .reset    (reset),
    .enable   (enable),
    .paReady  (paReady),
    .fetchAddr(fetchAddr),
    .busReady (busReady),
    .iStall   (iStall),
    .hRequestF(hRequestF),
    .rd       (rd)
);
